// File: rtl/rename_defines.svh
// Sizing for the rename stage
// Physical register 0 is hard-wired and never allocated
// RN_PREG_BITS must cover RN_NUM_PREGS - 1
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural register file size
`define RN_NUM_AREGS 32

// Physical register file size and index width
`define RN_NUM_PREGS 48
`define RN_PREG_BITS 6

// Default depth of input and output queues
`define RN_QUEUE_DEPTH 4

// In-flight counter width
// Must exceed the free pool size
`define RN_INFLIGHT_BITS 6

`endif

// File: rtl/isa_pkg.sv
// Architectural view of a decoded instruction
// The tag is opaque to the rename stage
`include "rename_defines.svh"

package isa_pkg;

  // ----------------------------------------------------------
  // Register names
  // ----------------------------------------------------------

  // Architectural register number
  // x0 is hard-wired
  typedef logic [$clog2(`RN_NUM_AREGS)-1:0] areg_t;

  // ----------------------------------------------------------
  // Decoded instruction
  // ----------------------------------------------------------

  // 32 bits total
  typedef struct packed {
    logic        has_dst;
    areg_t       dst;
    areg_t       src0;
    areg_t       src1;
    logic [15:0] tag;
  } dec_inst_t;

endpackage

// File: rtl/uarch_pkg.sv
// Microarchitectural types of the rename stage
// Widths follow the sizing macros
`include "rename_defines.svh"

package uarch_pkg;

  // ----------------------------------------------------------
  // Physical registers
  // ----------------------------------------------------------

  typedef logic [`RN_PREG_BITS-1:0] preg_t;

  // Source lookup result
  // Pending until its producer completes
  typedef struct packed {
    logic  pending;
    preg_t preg;
  } src_map_t;

  // ----------------------------------------------------------
  // Renamed instruction
  // ----------------------------------------------------------

  typedef struct packed {
    logic [15:0] tag;
    logic        has_dst;
    preg_t       dst;
    preg_t       ppreg;   // displaced mapping of dst
    src_map_t    src0;
    src_map_t    src1;
  } ren_inst_t;

  // Completion event from execute
  typedef struct packed {
    preg_t preg;
    preg_t ppreg;
  } complete_t;

  // Controller states
  typedef enum logic [1:0] {
    RUN     = 2'd0,
    STALL   = 2'd1,
    DRAIN   = 2'd2,
    DRAINED = 2'd3
  } ctrl_state_t;

endpackage

// File: rtl/sync_fifo.sv
// Single-clock first-word-fall-through queue
// A push while full is dropped
// A pop while empty is ignored
// Push and pop together are fine when not empty
`timescale 1ns/100ps
`include "rename_defines.svh"

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = `RN_QUEUE_DEPTH
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  T     wdata,
  input  logic pop,
  output T     rdata,
  output logic empty,
  output logic full
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Payload storage
  T mem [DEPTH];

  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS-1:0] wr_ptr;
  logic [CNT_BITS-1:0] count;

  logic do_push;
  logic do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // Wrap at DEPTH, not a power of two in general
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // Head presented combinationally
  assign rdata = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_BITS'(DEPTH));

endmodule

// File: rtl/rename_table.sv
// Rename map with pending bits and a lowest-first free list
// x0 maps to p0 and is never pending or renamed
// p0 is never freed
// A completion is seen by renames from the following cycle only
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_table (
  input  logic                clk,
  input  logic                rst,
  input  isa_pkg::dec_inst_t  head,
  input  logic                alloc_en,
  output logic                alloc_rdy,
  output uarch_pkg::ren_inst_t renamed,
  input  logic                cpl_val,
  input  uarch_pkg::complete_t cpl
);

  import uarch_pkg::*;

  // ----------------------------------------------------------
  // State
  // ----------------------------------------------------------

  // Entry i holds mapping of x(i)
  // No entry for x0
  src_map_t map [`RN_NUM_AREGS-1:1];

  // Bit i set when p(i) is free
  logic [`RN_NUM_PREGS-1:1] free_vec;

  // ----------------------------------------------------------
  // Lowest-free selection
  // ----------------------------------------------------------

  preg_t free_preg;
  logic  dst_is_x0;
  preg_t alloc_preg;
  preg_t alloc_ppreg;
  logic  alloc_take;

  // Scan downward so the lowest free index is the last to win
  always_comb begin
    free_preg = '0;
    for (int i = `RN_NUM_PREGS - 1; i >= 1; i--) begin
      if (free_vec[i]) begin
        free_preg = preg_t'(i);
      end
    end
  end

  assign dst_is_x0 = (head.dst == '0);

  // Writes to x0 use p0 and take nothing from the pool
  assign alloc_preg  = dst_is_x0 ? '0 : free_preg;
  assign alloc_ppreg = dst_is_x0 ? '0 : map[head.dst].preg;
  assign alloc_rdy   = (|free_vec) | dst_is_x0;
  assign alloc_take  = alloc_en & ~dst_is_x0;

  // ----------------------------------------------------------
  // Source lookup
  // ----------------------------------------------------------

  src_map_t src0_map;
  src_map_t src1_map;

  // Each source reads its own entry and pending bit
  always_comb begin
    if (head.src0 == '0) begin
      src0_map = '0;
    end else begin
      src0_map = map[head.src0];
    end
    if (head.src1 == '0) begin
      src1_map = '0;
    end else begin
      src1_map = map[head.src1];
    end
  end

  // ----------------------------------------------------------
  // Renamed instruction
  // ----------------------------------------------------------

  always_comb begin
    renamed.tag     = head.tag;
    renamed.has_dst = head.has_dst;
    renamed.dst     = head.has_dst ? alloc_preg : '0;
    renamed.ppreg   = head.has_dst ? alloc_ppreg : '0;
    renamed.src0    = src0_map;
    renamed.src1    = src1_map;
  end

  // ----------------------------------------------------------
  // Map update
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity mapping with nothing pending
      for (int i = 1; i < `RN_NUM_AREGS; i++) begin
        map[i] <= '{pending: 1'b0, preg: preg_t'(i)};
      end
    end else begin
      for (int i = 1; i < `RN_NUM_AREGS; i++) begin
        if (cpl_val && (map[i].preg == cpl.preg)) begin
          map[i].pending <= 1'b0;
        end
        // Allocation overrides the completion clear
        if (alloc_take && (head.dst == i)) begin
          map[i] <= '{pending: 1'b1, preg: alloc_preg};
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Free list update
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      // Regs above the architectural range start free
      for (int i = 1; i < `RN_NUM_PREGS; i++) begin
        free_vec[i] <= (i >= `RN_NUM_AREGS);
      end
    end else begin
      if (cpl_val && (cpl.ppreg != '0)) begin
        free_vec[cpl.ppreg] <= 1'b1;
      end
      if (alloc_take) begin
        free_vec[alloc_preg] <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/inflight_counter.sv
// Saturating up/down count of destinations awaiting completion
// inc and dec in the same cycle cancel
`timescale 1ns/100ps
`include "rename_defines.svh"

module inflight_counter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inc,
  input  logic                         dec,
  output logic [`RN_INFLIGHT_BITS-1:0] count,
  output logic                         zero
);

  localparam logic [`RN_INFLIGHT_BITS-1:0] CNT_MAX = '1;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      if (inc && !dec && (count != CNT_MAX)) begin
        count <= count + 1'b1;
      end else if (dec && !inc && (count != '0)) begin
        // Stray completion at zero is ignored
        count <= count - 1'b1;
      end
    end
  end

  // Read by the controller for drain
  assign zero = (count == '0);

endmodule

// File: rtl/rename_ctrl.sv
// Rename controller
// At most one rename per cycle
// stall and drain_done come straight from the state register
`timescale 1ns/100ps

module rename_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic in_empty,
  input  logic out_full,
  input  logic head_has_dst,
  input  logic alloc_rdy,
  input  logic drain,
  input  logic idle,
  output logic rename,
  output logic alloc_en,
  output logic stall,
  output logic drain_done
);

  import uarch_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        renaming_state;
  logic        no_reg;

  // ----------------------------------------------------------
  // Rename strobe
  // ----------------------------------------------------------

  assign renaming_state = (state == RUN) || (state == STALL);

  // Head wants a register the table cannot give
  assign no_reg = ~in_empty & head_has_dst & ~alloc_rdy;

  // Pops input queue and pushes output queue together
  assign rename   = renaming_state & ~in_empty & ~out_full &
                    (~head_has_dst | alloc_rdy);
  assign alloc_en = rename & head_has_dst;

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      RUN: begin
        if (drain) begin
          state_nxt = DRAIN;
        end else if (no_reg) begin
          state_nxt = STALL;
        end
      end
      STALL: begin
        if (drain) begin
          state_nxt = DRAIN;
        end else if (alloc_rdy) begin
          state_nxt = RUN;
        end
      end
      // Wait for every outstanding destination
      DRAIN: begin
        if (idle) begin
          state_nxt = DRAINED;
        end
      end
      DRAINED: begin
        if (!drain) begin
          state_nxt = RUN;
        end
      end
      default: state_nxt = RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RUN;
    end else begin
      state <= state_nxt;
    end
  end

  assign stall      = (state == STALL);
  assign drain_done = (state == DRAINED);

endmodule

// File: rtl/rename_unit.sv
// Register-rename stage top level
// A push while dec_full is high is lost
// Completions take effect for renames in the following cycle
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 dec_push,
  input  isa_pkg::dec_inst_t   dec_inst,
  output logic                 dec_full,
  input  logic                 out_pop,
  output uarch_pkg::ren_inst_t out_inst,
  output logic                 out_empty,
  input  logic                 cpl_val,
  input  uarch_pkg::complete_t cpl,
  input  logic                 drain,
  output logic                 stall,
  output logic                 drain_done
);

  import isa_pkg::*;
  import uarch_pkg::*;

  dec_inst_t head;
  ren_inst_t renamed;
  logic      in_empty;
  logic      out_full;
  logic      rename;
  logic      alloc_en;
  logic      alloc_rdy;
  logic      idle;

  // ----------------------------------------------------------
  // Queues
  // ----------------------------------------------------------

  sync_fifo #(.T(dec_inst_t), .DEPTH(`RN_QUEUE_DEPTH)) in_fifo_inst (
    .clk   (clk),
    .rst   (rst),
    .push  (dec_push),
    .wdata (dec_inst),
    .pop   (rename),
    .rdata (head),
    .empty (in_empty),
    .full  (dec_full)
  );

  sync_fifo #(.T(ren_inst_t), .DEPTH(`RN_QUEUE_DEPTH)) out_fifo_inst (
    .clk   (clk),
    .rst   (rst),
    .push  (rename),
    .wdata (renamed),
    .pop   (out_pop),
    .rdata (out_inst),
    .empty (out_empty),
    .full  (out_full)
  );

  // ----------------------------------------------------------
  // Table, counter, control
  // ----------------------------------------------------------

  rename_table rename_table_inst (
    .clk       (clk),
    .rst       (rst),
    .head      (head),
    .alloc_en  (alloc_en),
    .alloc_rdy (alloc_rdy),
    .renamed   (renamed),
    .cpl_val   (cpl_val),
    .cpl       (cpl)
  );

  inflight_counter inflight_counter_inst (
    .clk   (clk),
    .rst   (rst),
    .inc   (alloc_en),
    .dec   (cpl_val),
    .count (),
    .zero  (idle)
  );

  rename_ctrl rename_ctrl_inst (
    .clk          (clk),
    .rst          (rst),
    .in_empty     (in_empty),
    .out_full     (out_full),
    .head_has_dst (head.has_dst),
    .alloc_rdy    (alloc_rdy),
    .drain        (drain),
    .idle         (idle),
    .rename       (rename),
    .alloc_en     (alloc_en),
    .stall        (stall),
    .drain_done   (drain_done)
  );

endmodule

// File: verif/rename_model.svh
// Reference model of the rename map and free list for the testbench
// Included inside the testbench module after the package imports
// Assumes no completion arrives while a rename is still in flight
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

`include "rename_defines.svh"

// ------------------------------------------------------------
// Model state
// ------------------------------------------------------------

// Current mapping and pending bit per architectural register
preg_t model_map [`RN_NUM_AREGS];
logic  model_pend [`RN_NUM_AREGS];

// One bit per physical register, p0 never set
logic  model_free [`RN_NUM_PREGS];

// Identity map with the upper physical registers free
function automatic void model_reset();
  for (int i = 0; i < `RN_NUM_AREGS; i++) begin
    model_map[i]  = preg_t'(i);
    model_pend[i] = 1'b0;
  end
  for (int i = 0; i < `RN_NUM_PREGS; i++) begin
    model_free[i] = (i >= `RN_NUM_AREGS);
  end
endfunction

// x0 stays at p0 and never pending
function automatic src_map_t lookup_src(input areg_t a);
  src_map_t s;
  s.pending = model_pend[a];
  s.preg    = model_map[a];
  return s;
endfunction

// ------------------------------------------------------------
// Expected result, called in push order
// ------------------------------------------------------------

function automatic ren_inst_t rename_ref(input dec_inst_t d);
  ren_inst_t r;
  int        pick;
  r         = '0;
  r.tag     = d.tag;
  r.has_dst = d.has_dst;
  // Sources see the map before this instruction writes it
  r.src0    = lookup_src(d.src0);
  r.src1    = lookup_src(d.src1);
  if (d.has_dst && (d.dst != '0)) begin
    pick = -1;
    // Lowest free register wins
    for (int i = 1; i < `RN_NUM_PREGS; i++) begin
      if (model_free[i] && (pick < 0)) begin
        pick = i;
      end
    end
    if (pick > 0) begin
      r.dst               = preg_t'(pick);
      r.ppreg             = model_map[d.dst];
      model_free[pick]    = 1'b0;
      model_map[d.dst]    = preg_t'(pick);
      model_pend[d.dst]   = 1'b1;
    end
  end
  return r;
endfunction

// Clear pending on every mapping of preg and return ppreg to the pool
function automatic void model_complete(input complete_t c);
  for (int i = 1; i < `RN_NUM_AREGS; i++) begin
    if (model_map[i] == c.preg) begin
      model_pend[i] = 1'b0;
    end
  end
  if (c.ppreg != '0) begin
    model_free[c.ppreg] = 1'b1;
  end
endfunction

`endif

// File: verif/rename_tb.sv
// Self-checking testbench for the rename stage
// Completions are sent only once every expected result has been popped
// Pops happen at most every other cycle
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_tb;

  import isa_pkg::*;
  import uarch_pkg::*;

  `include "rename_model.svh"

  localparam int TIMEOUT_CYCLES = 200;

  logic        clk;
  logic        rst;
  logic        dec_push;
  dec_inst_t   dec_inst;
  logic        dec_full;
  logic        out_pop;
  ren_inst_t   out_inst;
  logic        out_empty;
  logic        cpl_val;
  complete_t   cpl;
  logic        drain;
  logic        stall;
  logic        drain_done;

  // Expected results in push order
  ren_inst_t   expect_q [$];
  // Completions still owed
  complete_t   cpl_q [$];

  string       test_name;
  int          errors;
  int          checks;
  logic        pop_enable;
  logic        out_empty_s;
  ren_inst_t   out_inst_s;
  logic [15:0] tag_seq;
  areg_t       last_dst;

  rename_unit rename_unit_inst (
    .clk        (clk),
    .rst        (rst),
    .dec_push   (dec_push),
    .dec_inst   (dec_inst),
    .dec_full   (dec_full),
    .out_pop    (out_pop),
    .out_inst   (out_inst),
    .out_empty  (out_empty),
    .cpl_val    (cpl_val),
    .cpl        (cpl),
    .drain      (drain),
    .stall      (stall),
    .drain_done (drain_done)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Output sampling and comparison
  // ------------------------------------------------------------

  // Outputs only move at rising edges
  always @(negedge clk) begin
    out_empty_s = out_empty;
    out_inst_s  = out_inst;
  end

  // Head checked, then popped at the end of this cycle
  always @(posedge clk) begin
    ren_inst_t want;
    if (rst || out_pop || !pop_enable || out_empty_s) begin
      out_pop <= 1'b0;
    end else begin
      out_pop <= 1'b1;
      checks++;
      if (expect_q.size() == 0) begin
        errors++;
        $display("[%s] output with tag %h appeared while nothing was expected",
                 test_name, out_inst_s.tag);
      end else begin
        want = expect_q.pop_front();
        if (out_inst_s !== want) begin
          errors++;
          $display("** Error [%s] out_inst: expected %h, actual %h",
                   test_name, want, out_inst_s);
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  function automatic logic flag_value(input string name);
    if (name == "stall") begin
      return stall;
    end else if (name == "drain_done") begin
      return drain_done;
    end else if (name == "dec_full") begin
      return dec_full;
    end
    return out_empty;
  endfunction

  function automatic void check_flag(input string name, input logic want);
    checks++;
    if (flag_value(name) !== want) begin
      errors++;
      $display("** Error [%s] %s: expected %0b, actual %0b",
               test_name, name, want, flag_value(name));
    end
  endfunction

  // Level must hold for a number of cycles
  task automatic hold_flag(input string name, input logic want, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_flag(name, want);
    end
  endtask

  task automatic wait_flag(input string name, input logic want);
    int n;
    n = 0;
    @(negedge clk);
    while ((flag_value(name) !== want) && (n < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      n++;
    end
    if (flag_value(name) !== want) begin
      errors++;
      $display("[%s] timed out waiting for %s to become %0b", test_name, name, want);
    end
  endtask

  task automatic wait_outputs();
    int n;
    n = 0;
    @(negedge clk);
    while ((expect_q.size() != 0) && (n < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      n++;
    end
    if (expect_q.size() != 0) begin
      errors++;
      $display("[%s] timed out with %0d renamed instructions never seen",
               test_name, expect_q.size());
      expect_q.delete();
    end
  endtask

  // Random fields
  // src0 often reads the latest writer
  function automatic dec_inst_t rand_inst(input bit with_dst);
    dec_inst_t d;
    d.has_dst = with_dst;
    d.dst     = areg_t'(1 + ($urandom % 31));
    d.src0    = areg_t'($urandom % 32);
    d.src1    = areg_t'($urandom % 32);
    if ((last_dst != '0) && ($urandom % 2 == 1)) begin
      d.src0 = last_dst;
    end
    d.tag = tag_seq;
    tag_seq++;
    if (with_dst) begin
      last_dst = d.dst;
    end
    return d;
  endfunction

  function automatic void expect_inst(input dec_inst_t d);
    ren_inst_t r;
    r = rename_ref(d);
    expect_q.push_back(r);
    if (r.has_dst) begin
      cpl_q.push_back('{preg: r.dst, ppreg: r.ppreg});
    end
  endfunction

  // One push strobe with an optional wait for room
  task automatic drive_inst(input dec_inst_t d, input bit wait_room);
    int n;
    n = 0;
    @(negedge clk);
    while (wait_room && dec_full && (n < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      n++;
    end
    if (wait_room && dec_full) begin
      errors++;
      $display("[%s] timed out waiting for room in the input queue", test_name);
    end else begin
      @(posedge clk);
      dec_push <= 1'b1;
      dec_inst <= d;
      @(posedge clk);
      dec_push <= 1'b0;
    end
  endtask

  task automatic send_inst(input dec_inst_t d);
    expect_inst(d);
    drive_inst(d, 1'b1);
  endtask

  task automatic send_cpl(input complete_t c);
    model_complete(c);
    @(posedge clk);
    cpl_val <= 1'b1;
    cpl     <= c;
    @(posedge clk);
    cpl_val <= 1'b0;
  endtask

  task automatic complete_all();
    while (cpl_q.size() != 0) begin
      send_cpl(cpl_q.pop_front());
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    dec_inst_t d;
    complete_t c;
    void'($urandom(32'habfb_fbe4));
    rst         = 1'b1;
    dec_push    = 1'b0;
    dec_inst    = '0;
    out_pop     = 1'b0;
    cpl_val     = 1'b0;
    cpl         = '0;
    drain       = 1'b0;
    pop_enable  = 1'b1;
    out_empty_s = 1'b1;
    out_inst_s  = '0;
    errors      = 0;
    checks      = 0;
    tag_seq     = '0;
    last_dst    = '0;
    test_name   = "reset";
    model_reset();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag("out_empty", 1'b1);
    check_flag("dec_full", 1'b0);
    check_flag("stall", 1'b0);
    check_flag("drain_done", 1'b0);

    // Identity map with nothing pending
    test_name = "identity_no_dst";
    repeat (6) send_inst(rand_inst(1'b0));
    wait_outputs();

    // Fresh registers from 32 upward
    test_name = "random_alloc";
    repeat (10) send_inst(rand_inst(1'b1));
    wait_outputs();

    // Completed sources clear and freed ppregs come back lowest first
    test_name = "complete_reuse";
    complete_all();
    repeat (8) send_inst(rand_inst($urandom % 2 == 1));
    wait_outputs();
    complete_all();

    // All 16 free registers taken so the next one stalls
    test_name = "exhaust_stall";
    repeat (16) send_inst(rand_inst(1'b1));
    wait_outputs();
    d = rand_inst(1'b1);
    drive_inst(d, 1'b1);
    wait_flag("stall", 1'b1);
    hold_flag("out_empty", 1'b1, 4);
    c = cpl_q.pop_front();
    send_cpl(c);
    expect_inst(d);
    wait_outputs();
    wait_flag("stall", 1'b0);
    complete_all();

    // Both queues fill and an extra push is lost
    test_name = "backpressure";
    @(posedge clk);
    pop_enable <= 1'b0;
    repeat (8) send_inst(rand_inst($urandom % 2 == 1));
    wait_flag("dec_full", 1'b1);
    check_flag("out_empty", 1'b0);
    drive_inst(rand_inst(1'b0), 1'b0);
    hold_flag("dec_full", 1'b1, 2);
    @(posedge clk);
    pop_enable <= 1'b1;
    wait_outputs();
    hold_flag("out_empty", 1'b1, 6);
    check_flag("dec_full", 1'b0);
    complete_all();

    // Drain waits for every outstanding destination
    test_name = "drain";
    repeat (3) send_inst(rand_inst(1'b1));
    wait_outputs();
    @(posedge clk);
    drain <= 1'b1;
    hold_flag("drain_done", 1'b0, 4);
    check_flag("stall", 1'b0);
    while (cpl_q.size() > 1) begin
      send_cpl(cpl_q.pop_front());
    end
    hold_flag("drain_done", 1'b0, 3);
    send_cpl(cpl_q.pop_front());
    wait_flag("drain_done", 1'b1);
    // Held in the input queue until drain falls
    send_inst(rand_inst(1'b1));
    hold_flag("out_empty", 1'b1, 4);
    @(posedge clk);
    drain <= 1'b0;
    wait_outputs();
    wait_flag("drain_done", 1'b0);
    complete_all();

    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+rtl
+incdir+verif
rtl/isa_pkg.sv
rtl/uarch_pkg.sv
rtl/sync_fifo.sv
rtl/rename_table.sv
rtl/inflight_counter.sv
rtl/rename_ctrl.sv
rtl/rename_unit.sv
verif/rename_tb.sv

// File: Bender.yml
package:
  name: rename_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/uarch_pkg.sv
      - rtl/sync_fifo.sv
      - rtl/rename_table.sv
      - rtl/inflight_counter.sv
      - rtl/rename_ctrl.sv
      - rtl/rename_unit.sv
  - target: simulation
    include_dirs:
      - rtl
      - verif
    files:
      - verif/rename_tb.sv
